// ==== compile.f ====
+incdir+include
design/execPkg.sv
design/execRegs.sv
design/shiftAlu.sv
design/multUnit.sv
design/resultSelect.sv
design/execTop.sv
verification/execTb.sv

// ==== design/execPkg.sv ====
package execPkg;

  // Data-processing opcodes, ARM encoding order
  typedef enum logic [3:0] {
    OP_AND, OP_EOR, OP_SUB, OP_RSB,
    OP_ADD, OP_ADC, OP_SBC, OP_RSC,
    OP_TST, OP_TEQ, OP_CMP, OP_CMN,
    OP_ORR, OP_MOV, OP_BIC, OP_MVN
  } aluOp;

  // Shift types for the register form of operand 2
  typedef enum logic [1:0] {SH_LSL, SH_LSR, SH_ASR, SH_ROR} shiftType;

  // Condition flags, same order as the CPSR top nibble
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // Data-processing view
  // Operand2 is rot/imm8 or shamt/type/0/Rm, split in the shifter
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  zero;
    logic        imm;
    aluOp        opcode;
    logic        s;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] operand2;
  } dpWord;

  // Multiply view, MUL and MLA
  typedef struct packed {
    logic [3:0] cond;
    logic [5:0] zero;
    logic       acc;
    logic       s;
    logic [3:0] rd;
    logic [3:0] rn;
    logic [3:0] rs;
    logic [3:0] pattern;
    logic [3:0] rm;
  } mulWord;

  // One instruction word, two decodes
  typedef union packed {
    dpWord  dp;
    mulWord mul;
  } instrWord;

  // Multiply class: bits 27:22 clear and 1001 in bits 7:4
  function automatic logic isMulWord(instrWord w);
    return (w.mul.zero == 6'b0) && (w.mul.pattern == 4'b1001);
  endfunction

endpackage

// ==== design/execRegs.sv ====
`timescale 1ns/1ps
`include "exec_defs.svh"

module execRegs (
  input  logic                    clk,
  input  logic                    rstN,
  // APB3 slave
  input  logic [`EXEC_ADDR_W-1:0] paddr,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [31:0]             pwdata,
  output logic [31:0]             prdata,
  output logic                    pready,
  output logic                    pslverr,
  // From the result stage
  input  logic                    done,
  input  logic [31:0]             result,
  input  execPkg::flagsT          flags,
  // To both lanes
  output logic                    start,
  output execPkg::instrWord       instr,
  output logic [31:0]             opA,
  output logic [31:0]             opB,
  output logic [31:0]             opC
);

  logic        access;
  logic        wrAcc;
  logic        hitOpA;
  logic        hitOpB;
  logic        hitOpC;
  logic        hitInstr;
  logic        hitResult;
  logic        hitStatus;
  logic        mapped;
  logic        instrAccept;
  logic        busy;
  logic        doneSt;
  logic [31:0] statusWord;
  logic [31:0] readMux;

  // ===================================================================
  // APB decode
  // ===================================================================

  // Access phase only, setup phase never commits anything
  assign access = psel & penable;
  assign wrAcc  = access & pwrite;

  assign hitOpA    = (paddr == `EXEC_OPA);
  assign hitOpB    = (paddr == `EXEC_OPB);
  assign hitOpC    = (paddr == `EXEC_OPC);
  assign hitInstr  = (paddr == `EXEC_INSTR);
  assign hitResult = (paddr == `EXEC_RESULT);
  assign hitStatus = (paddr == `EXEC_STATUS);
  assign mapped    = hitOpA | hitOpB | hitOpC | hitInstr | hitResult | hitStatus;

  // New work only when idle
  // start is checked too, busy rises one cycle after it
  assign instrAccept = wrAcc & hitInstr & ~busy & ~start;

  // Zero wait states
  assign pready = 1'b1;

  // Unmapped, read-only target, or INSTR refused while busy
  assign pslverr = access & (~mapped
                             | (pwrite & (hitResult | hitStatus))
                             | (pwrite & hitInstr & (busy | start)));

  // ===================================================================
  // Operand and instruction registers
  // ===================================================================

  // Operands may be rewritten while busy
  // The lanes sampled them on start already
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      opA   <= '0;
      opB   <= '0;
      opC   <= '0;
      instr <= '0;
    end else begin
      if (wrAcc && hitOpA) opA <= pwdata;
      if (wrAcc && hitOpB) opB <= pwdata;
      if (wrAcc && hitOpC) opC <= pwdata;
      // Held steady until done, result stage decodes from it
      if (instrAccept) instr <= execPkg::instrWord'(pwdata);
    end
  end

  // Start pulse, busy window and sticky done
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      start  <= 1'b0;
      busy   <= 1'b0;
      doneSt <= 1'b0;
    end else begin
      start <= instrAccept;
      if (start) begin
        busy   <= 1'b1;
        doneSt <= 1'b0;
      end else if (done) begin
        busy   <= 1'b0;
        doneSt <= 1'b1;
      end
    end
  end

  // ===================================================================
  // Read-back
  // ===================================================================

  always_comb begin
    statusWord = '0;
    statusWord[`EXEC_ST_FLAGS_LSB +: 4] = flags;
    statusWord[`EXEC_ST_BUSY]           = busy;
    statusWord[`EXEC_ST_DONE]           = doneSt;
  end

  always_comb begin
    readMux = '0;
    if (hitOpA)    readMux = opA;
    if (hitOpB)    readMux = opB;
    if (hitOpC)    readMux = opC;
    if (hitInstr)  readMux = instr;
    if (hitResult) readMux = result;
    if (hitStatus) readMux = statusWord;
  end

  // Drive data only during a read
  assign prdata = (psel & ~pwrite) ? readMux : '0;

  // One operation in flight
  aStartIdle: assert property (@(posedge clk) disable iff (!rstN)
    $rose(start) |-> !busy);

  // Result stage only finishes what this block launched
  aDoneBusy: assert property (@(posedge clk) disable iff (!rstN)
    done |-> busy);

endmodule

// ==== design/execTop.sv ====
`timescale 1ns/1ps

module execTop (
  input  logic        clk,
  input  logic        rstN,
  input  logic [7:0]  paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  logic              start;
  execPkg::instrWord instr;
  logic [31:0]       opA;
  logic [31:0]       opB;
  logic [31:0]       opC;
  logic [31:0]       aluResult;
  execPkg::flagsT    aluFlags;
  logic              aluValid;
  logic [31:0]       mulResult;
  execPkg::flagsT    mulFlags;
  logic              mulValid;
  logic [31:0]       result;
  execPkg::flagsT    flags;
  logic              done;

  // APB front end and operand store
  execRegs regs0 (.clk, .rstN, .paddr, .psel, .penable, .pwrite, .pwdata,
                  .prdata, .pready, .pslverr, .done, .result, .flags,
                  .start, .instr, .opA, .opB, .opC);

  // Shifter and ALU lane, stored flags feed carry-in and RRX
  shiftAlu alu0 (.clk, .rstN, .start, .instr, .opA, .opB, .flagsIn(flags),
                 .aluResult, .aluFlags, .aluValid);

  // Two-stage multiply lane
  multUnit mul0 (.clk, .rstN, .start, .instr, .opA, .opB, .opC,
                 .mulResult, .mulFlags, .mulValid);

  // Lane select, result and NZCV
  resultSelect res0 (.clk, .rstN, .instr, .aluResult, .aluFlags, .aluValid,
                     .mulResult, .mulFlags, .mulValid, .result, .flags, .done);

endmodule

// ==== design/multUnit.sv ====
`timescale 1ns/1ps

module multUnit (
  input  logic              clk,
  input  logic              rstN,
  input  logic              start,
  input  execPkg::instrWord instr,
  input  logic [31:0]       opA,
  input  logic [31:0]       opB,
  input  logic [31:0]       opC,
  output logic [31:0]       mulResult,
  output execPkg::flagsT    mulFlags,
  output logic              mulValid
);

  logic        go;
  logic [31:0] product;
  // Stage 1 holding registers
  logic        valid1;
  logic [31:0] prod1;
  logic        acc1;
  logic [31:0] addend1;
  // Stage 2 sum
  logic [31:0] mac;

  // Only multiply-class words enter
  assign go = start & execPkg::isMulWord(instr);

  // Low word only, sign does not matter here
  assign product = opA * opB;

  // ===================================================================
  // Stage 1: product
  // ===================================================================

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) valid1 <= 1'b0;
    else       valid1 <= go;
  end

  // Accumulate bit and opC travel with the product
  always_ff @(posedge clk) begin
    if (go) begin
      prod1   <= product;
      acc1    <= instr.mul.acc;
      addend1 <= opC;
    end
  end

  // ===================================================================
  // Stage 2: accumulate and flags
  // ===================================================================

  // MLA adds opC, MUL adds zero
  assign mac = prod1 + (acc1 ? addend1 : 32'd0);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) mulValid <= 1'b0;
    else       mulValid <= valid1;
  end

  always_ff @(posedge clk) begin
    if (valid1) begin
      mulResult  <= mac;
      mulFlags.n <= mac[31];
      mulFlags.z <= (mac == 32'd0);
      // C and V come from the stored flags in the result stage
      mulFlags.c <= 1'b0;
      mulFlags.v <= 1'b0;
    end
  end

endmodule

// ==== design/resultSelect.sv ====
`timescale 1ns/1ps

module resultSelect (
  input  logic              clk,
  input  logic              rstN,
  input  execPkg::instrWord instr,
  input  logic [31:0]       aluResult,
  input  execPkg::flagsT    aluFlags,
  input  logic              aluValid,
  input  logic [31:0]       mulResult,
  input  execPkg::flagsT    mulFlags,
  input  logic              mulValid,
  output logic [31:0]       result,
  output execPkg::flagsT    flags,
  output logic              done
);

  logic isMul;
  logic sBit;
  logic cmpOnly;
  logic laneValid;

  // instr is the register block's copy, fixed from start to done
  assign isMul = execPkg::isMulWord(instr);
  // S sits at bit 20 in both views
  assign sBit  = instr.dp.s;

  // TST, TEQ, CMP, CMN set flags without a result
  assign cmpOnly = ~isMul && (instr.dp.opcode inside {execPkg::OP_TST, execPkg::OP_TEQ,
                                                     execPkg::OP_CMP, execPkg::OP_CMN});

  assign laneValid = isMul ? mulValid : aluValid;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      result <= '0;
      flags  <= '0;
      done   <= 1'b0;
    end else begin
      done <= laneValid;
      if (laneValid) begin
        if (isMul) begin
          result <= mulResult;
          // Multiply touches N and Z only
          if (sBit) begin
            flags.n <= mulFlags.n;
            flags.z <= mulFlags.z;
          end
        end else begin
          if (!cmpOnly) result <= aluResult;
          if (sBit || cmpOnly) flags <= aluFlags;
        end
      end
    end
  end

  // Each lane fires only for its own class of word
  aAluLane: assert property (@(posedge clk) disable iff (!rstN)
    aluValid |-> !isMul);
  aMulLane: assert property (@(posedge clk) disable iff (!rstN)
    mulValid |-> isMul);

endmodule

// ==== design/shiftAlu.sv ====
`timescale 1ns/1ps

module shiftAlu (
  input  logic              clk,
  input  logic              rstN,
  input  logic              start,
  input  execPkg::instrWord instr,
  input  logic [31:0]       opA,
  input  logic [31:0]       opB,
  input  execPkg::flagsT    flagsIn,
  output logic [31:0]       aluResult,
  output execPkg::flagsT    aluFlags,
  output logic              aluValid
);

  logic               go;
  // Immediate form
  logic [3:0]         rot;
  logic [31:0]        imm32;
  logic [63:0]        rotWide;
  logic [31:0]        immVal;
  logic               immCarry;
  // Register form
  logic [4:0]         shamt;
  execPkg::shiftType  shType;
  logic [32:0]        lslWide;
  logic [32:0]        lsrWide;
  logic signed [32:0] asrWide;
  logic [63:0]        rorWide;
  logic [31:0]        regVal;
  logic               regCarry;
  // Operand 2 and shifter carry
  logic [31:0]        op2;
  logic               shCarry;
  // Adder
  logic [31:0]        addA;
  logic [31:0]        addB;
  logic               addCin;
  logic [32:0]        sum;
  logic               addV;
  logic               isArith;
  logic [31:0]        logicRes;
  logic [31:0]        res;
  execPkg::flagsT     newFlags;

  // Multiply words belong to the other lane
  assign go = start & ~execPkg::isMulWord(instr);

  // ===================================================================
  // Operand 2
  // ===================================================================

  // imm8 rotated right by 2*rot
  assign rot      = instr.dp.operand2[11:8];
  assign imm32    = {24'b0, instr.dp.operand2[7:0]};
  assign rotWide  = {imm32, imm32} >> {rot, 1'b0};
  assign immVal   = rotWide[31:0];
  assign immCarry = (rot != 4'd0) ? immVal[31] : flagsIn.c;

  // Shift by constant, bit 4 of operand2 is zero here
  assign shamt   = instr.dp.operand2[11:7];
  assign shType  = execPkg::shiftType'(instr.dp.operand2[6:5]);
  assign lslWide = {1'b0, opB} << shamt;
  assign lsrWide = {opB, 1'b0} >> shamt;
  assign asrWide = $signed({opB, 1'b0}) >>> shamt;
  assign rorWide = {opB, opB} >> shamt;

  always_comb begin
    regVal   = opB;
    regCarry = flagsIn.c;
    case (shType)
      execPkg::SH_LSL: begin
        // LSL #0 passes opB and keeps C
        if (shamt != 5'd0) begin
          regVal   = lslWide[31:0];
          regCarry = lslWide[32];
        end
      end
      execPkg::SH_LSR: begin
        // Amount 0 encodes LSR #32
        regVal   = (shamt == 5'd0) ? 32'd0 : lsrWide[32:1];
        regCarry = (shamt == 5'd0) ? opB[31] : lsrWide[0];
      end
      execPkg::SH_ASR: begin
        // Amount 0 encodes ASR #32
        regVal   = (shamt == 5'd0) ? {32{opB[31]}} : asrWide[32:1];
        regCarry = (shamt == 5'd0) ? opB[31] : asrWide[0];
      end
      default: begin
        // ROR #0 is RRX through stored C
        regVal   = (shamt == 5'd0) ? {flagsIn.c, opB[31:1]} : rorWide[31:0];
        regCarry = (shamt == 5'd0) ? opB[0] : rorWide[31];
      end
    endcase
  end

  assign op2     = instr.dp.imm ? immVal : regVal;
  assign shCarry = instr.dp.imm ? immCarry : regCarry;

  // ===================================================================
  // ALU, single adder with inversion and carry-in
  // ===================================================================

  always_comb begin
    addA     = opA;
    addB     = ~op2;
    addCin   = 1'b1;
    isArith  = 1'b1;
    logicRes = 32'd0;
    case (instr.dp.opcode)
      execPkg::OP_SUB, execPkg::OP_CMP: ;
      execPkg::OP_RSB: begin
        addA = op2;
        addB = ~opA;
      end
      execPkg::OP_ADD, execPkg::OP_CMN: begin
        addB   = op2;
        addCin = 1'b0;
      end
      execPkg::OP_ADC: begin
        addB   = op2;
        addCin = flagsIn.c;
      end
      execPkg::OP_SBC: addCin = flagsIn.c;
      execPkg::OP_RSC: begin
        addA   = op2;
        addB   = ~opA;
        addCin = flagsIn.c;
      end
      default: begin
        // Logical group
        isArith = 1'b0;
        case (instr.dp.opcode)
          execPkg::OP_AND, execPkg::OP_TST: logicRes = opA & op2;
          execPkg::OP_EOR, execPkg::OP_TEQ: logicRes = opA ^ op2;
          execPkg::OP_ORR: logicRes = opA | op2;
          execPkg::OP_MOV: logicRes = op2;
          execPkg::OP_BIC: logicRes = opA & ~op2;
          default:         logicRes = ~op2;
        endcase
      end
    endcase
  end

  assign sum  = {1'b0, addA} + {1'b0, addB} + {32'd0, addCin};
  // Same-sign inputs, different-sign output
  assign addV = (addA[31] == addB[31]) && (sum[31] != addA[31]);

  // Arithmetic ops take the adder output
  assign res = isArith ? sum[31:0] : logicRes;

  // Logical ops take the shifter carry and keep V
  assign newFlags.n = res[31];
  assign newFlags.z = (res == 32'd0);
  assign newFlags.c = isArith ? sum[32] : shCarry;
  assign newFlags.v = isArith ? addV : flagsIn.v;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) aluValid <= 1'b0;
    else       aluValid <= go;
  end

  // Payload, qualified by aluValid
  always_ff @(posedge clk) begin
    if (go) begin
      aluResult <= res;
      aluFlags  <= newFlags;
    end
  end

  // Lane latency is one cycle from the register block's start
  aAluLatency: assert property (@(posedge clk) disable iff (!rstN)
    aluValid |-> $past(start));

endmodule

// ==== include/exec_defs.svh ====
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// APB address width of the execute unit
`define EXEC_ADDR_W 8

// Register map, byte offsets
`define EXEC_OPA    8'h00
`define EXEC_OPB    8'h04
`define EXEC_OPC    8'h08
`define EXEC_INSTR  8'h0C
`define EXEC_RESULT 8'h10
`define EXEC_STATUS 8'h14

// STATUS bit positions
// Done stays set until the next start
`define EXEC_ST_DONE      0
`define EXEC_ST_BUSY      1
// NZCV occupies four bits from here up
`define EXEC_ST_FLAGS_LSB 28

`endif

// ==== run.sh ====
#!/bin/sh
# Build the execute unit testbench with Verilator and run it
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f compile.f --top-module execTb -o execSim \
  && ./obj_dir/execSim > sim.log 2>&1 \
  || echo "Simulation FAILED" >> sim.log
cat sim.log
if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
exit 0

// ==== verification/execTb.sv ====
`timescale 1ns/1ps
`include "exec_defs.svh"

module execTb;

  localparam int ResetCycles    = 16;
  localparam int NumInstr       = 300;
  localparam int CyclesPerInstr = 30;
  localparam int CycleLimit     = ResetCycles + NumInstr * CyclesPerInstr;
  localparam int MaxPolls       = 20;

  logic        clk;
  logic        rstN;
  logic [7:0]  paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  // Reference state, flags ordered n z c v
  logic [3:0]  mFlags  = 4'd0;
  logic [31:0] mResult = 32'd0;

  int seed   = 81052;
  int checks = 0;
  int errors = 0;
  int checks0 = 0;
  int errors0 = 0;
  int cycles = 0;

  execTop dut0 (.clk, .rstN, .paddr, .psel, .penable, .pwrite, .pwdata,
                .prdata, .pready, .pslverr);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Hard stop on a stuck run
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("Timeout: run exceeded %0d cycles", CycleLimit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // ====================================================================
  // Checks and APB transfers
  // ====================================================================

  task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic reportTest(input int num, input string label);
    $display("Test %0d %s: %0d checks, %0d errors", num, label,
             checks - checks0, errors - errors0);
    checks0 = checks;
    errors0 = errors;
  endtask

  // Setup on one falling edge, access on the next, sample at the commit edge
  task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, output logic err);
    @(negedge clk);
    paddr   = addr;
    pwrite  = 1'b1;
    pwdata  = data;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    err = pslverr;
    // Zero wait states, every access completes here
    checkVal("pready", {31'd0, pready}, 32'd1);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, output logic err);
    @(negedge clk);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    data = prdata;
    err  = pslverr;
    checkVal("pready", {31'd0, pready}, 32'd1);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // ====================================================================
  // Reference model
  // ====================================================================

  // Returns {carry, operand 2}
  function automatic logic [32:0] operand2Model(input logic [31:0] w, input logic [31:0] b,
                                                input logic cIn);
    int                 amt;
    logic [31:0]        val;
    logic               cy;
    logic [63:0]        wide;
    logic signed [63:0] swide;
    if (w[25]) begin
      amt = 2 * int'(w[11:8]);
      val = {24'd0, w[7:0]};
      cy  = cIn;
      if (amt != 0) begin
        val = (val >> amt) | (val << (32 - amt));
        cy  = val[31];
      end
    end else begin
      amt = int'(w[11:7]);
      val = b;
      cy  = cIn;
      // Zero amount on LSR and ASR stands for 32
      if (amt == 0 && (w[6:5] == 2'd1 || w[6:5] == 2'd2)) amt = 32;
      case (w[6:5])
        2'd0: begin
          wide = {32'd0, b} << amt;
          if (amt != 0) begin
            val = wide[31:0];
            cy  = wide[32];
          end
        end
        2'd1: begin
          wide = {b, 32'd0} >> amt;
          val  = wide[63:32];
          cy   = wide[31];
        end
        2'd2: begin
          swide = $signed({b, 32'd0}) >>> amt;
          val   = swide[63:32];
          cy    = swide[31];
        end
        default: begin
          if (amt == 0) begin
            // RRX
            val = {cIn, b[31:1]};
            cy  = b[0];
          end else begin
            wide = {b, b} >> amt;
            val  = wide[31:0];
            cy   = val[31];
          end
        end
      endcase
    end
    return {cy, val};
  endfunction

  // Overflow when the exact signed sum does not fit in 32 bits
  task automatic addModel(input logic [31:0] x, input logic [31:0] y, input logic cin,
                          output logic [31:0] r, output logic c, output logic v);
    logic [32:0] s;
    longint      sx;
    s  = {1'b0, x} + {1'b0, y} + {32'd0, cin};
    r  = s[31:0];
    c  = s[32];
    sx = longint'($signed(x)) + longint'($signed(y)) + longint'(cin);
    v  = (sx != longint'($signed(r)));
  endtask

  // C is the ARM not-borrow
  task automatic subModel(input logic [31:0] x, input logic [31:0] y, input logic borrow,
                          output logic [31:0] r, output logic c, output logic v);
    longint sx;
    r  = x - y - {31'd0, borrow};
    c  = ({1'b0, x} >= ({1'b0, y} + {32'd0, borrow}));
    sx = longint'($signed(x)) - longint'($signed(y)) - longint'(borrow);
    v  = (sx != longint'($signed(r)));
  endtask

  task automatic modelDp(input logic [31:0] w, input logic [31:0] a, input logic [31:0] b);
    logic [32:0] sh;
    logic [31:0] o;
    logic [31:0] r;
    logic [3:0]  op;
    logic        c;
    logic        v;
    sh = operand2Model(w, b, mFlags[1]);
    o  = sh[31:0];
    op = w[24:21];
    // Logical ops keep the shifter carry and V
    c  = sh[32];
    v  = mFlags[0];
    case (op)
      4'h0, 4'h8: r = a & o;
      4'h1, 4'h9: r = a ^ o;
      4'h2, 4'hA: subModel(a, o, 1'b0, r, c, v);
      4'h3:       subModel(o, a, 1'b0, r, c, v);
      4'h4, 4'hB: addModel(a, o, 1'b0, r, c, v);
      4'h5:       addModel(a, o, mFlags[1], r, c, v);
      4'h6:       subModel(a, o, ~mFlags[1], r, c, v);
      4'h7:       subModel(o, a, ~mFlags[1], r, c, v);
      4'hC:       r = a | o;
      4'hD:       r = o;
      4'hE:       r = a & ~o;
      default:    r = ~o;
    endcase
    // TST TEQ CMP CMN always set flags, never write the result
    if (w[20] || op[3:2] == 2'b10) mFlags = {r[31], (r == 32'd0), c, v};
    if (op[3:2] != 2'b10) mResult = r;
  endtask

  task automatic modelMul(input logic [31:0] w, input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] c);
    logic [31:0] r;
    r = a * b + (w[21] ? c : 32'd0);
    mResult = r;
    if (w[20]) mFlags[3:2] = {r[31], (r == 32'd0)};
  endtask

  // ====================================================================
  // Operation sequencing
  // ====================================================================

  task automatic waitDone(output logic [31:0] st);
    int   polls;
    logic err;
    polls = 0;
    st    = 32'd0;
    while (!st[`EXEC_ST_DONE] && polls < MaxPolls) begin
      apbRead(`EXEC_STATUS, st, err);
      polls++;
    end
    if (!st[`EXEC_ST_DONE]) begin
      errors++;
      $display("Error: done bit still clear after %0d STATUS polls", MaxPolls);
    end
    checkVal("STATUS.BUSY", {31'd0, st[`EXEC_ST_BUSY]}, 32'd0);
  endtask

  task automatic checkOutcome();
    logic [31:0] st;
    logic [31:0] rd;
    logic        err;
    waitDone(st);
    apbRead(`EXEC_RESULT, rd, err);
    checkVal("RESULT", rd, mResult);
    checkVal("STATUS.NZCV", {28'd0, st[`EXEC_ST_FLAGS_LSB +: 4]}, {28'd0, mFlags});
  endtask

  task automatic runOp(input logic [31:0] w, input logic isMul, input logic [31:0] a,
                       input logic [31:0] b, input logic [31:0] c);
    logic err;
    apbWrite(`EXEC_OPA, a, err);
    apbWrite(`EXEC_OPB, b, err);
    apbWrite(`EXEC_OPC, c, err);
    apbWrite(`EXEC_INSTR, w, err);
    checkVal("pslverr", {31'd0, err}, 32'd0);
    if (isMul) modelMul(w, a, b, c);
    else       modelDp(w, a, b);
    checkOutcome();
  endtask

  // ====================================================================
  // Stimulus
  // ====================================================================

  initial begin
    int          i;
    logic [31:0] rnd;
    logic [31:0] rnd2;
    logic [31:0] w;
    logic [31:0] rd;
    logic        err;
    rstN    = 1'b0;
    paddr   = 8'd0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = 32'd0;
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    // Idle state and bad address
    apbRead(`EXEC_STATUS, rd, err);
    checkVal("STATUS", rd, 32'd0);
    apbRead(`EXEC_RESULT, rd, err);
    checkVal("RESULT", rd, 32'd0);
    apbRead(8'h18, rd, err);
    checkVal("pslverr", {31'd0, err}, 32'd1);
    apbWrite(`EXEC_STATUS, 32'hFFFF_FFFF, err);
    checkVal("pslverr", {31'd0, err}, 32'd1);
    reportTest(1, "reset and decode");

    // Immediate operand 2, opcode walks all sixteen
    for (i = 0; i < 120; i++) begin
      rnd = $random(seed);
      w   = {4'hE, 2'b00, 1'b1, i[3:0], rnd[20:0]};
      runOp(w, 1'b0, $random(seed), $random(seed), 32'd0);
    end
    reportTest(2, "immediate data-processing");

    // Register shifts, some with amount 0 for LSR/ASR #32 and RRX
    for (i = 0; i < 120; i++) begin
      rnd  = $random(seed);
      rnd2 = $random(seed);
      w    = {4'hE, 2'b00, 1'b0, rnd2[3:0], rnd[20:5], 1'b0, rnd[3:0]};
      if (rnd2[5:4] == 2'd0) w[11:7] = 5'd0;
      runOp(w, 1'b0, $random(seed), $random(seed), 32'd0);
    end
    reportTest(3, "register-shift data-processing");

    // MUL and MLA with random S and accumulate
    for (i = 0; i < 60; i++) begin
      rnd = $random(seed);
      w   = {4'hE, 6'b0, rnd[21], rnd[20], rnd[19:8], 4'b1001, rnd[3:0]};
      runOp(w, 1'b1, $random(seed), $random(seed), $random(seed));
    end
    reportTest(4, "multiply");

    // Second INSTR write lands while the MLA is busy
    rnd = $random(seed);
    w   = {4'hE, 6'b0, 1'b1, 1'b1, rnd[19:8], 4'b1001, rnd[3:0]};
    apbWrite(`EXEC_OPA, 32'h0001_2345, err);
    apbWrite(`EXEC_OPB, 32'hFFFF_FF03, err);
    apbWrite(`EXEC_OPC, 32'h8000_0010, err);
    apbWrite(`EXEC_INSTR, w, err);
    checkVal("pslverr", {31'd0, err}, 32'd0);
    apbWrite(`EXEC_INSTR, {4'hE, 2'b00, 1'b1, 4'hD, 1'b1, 20'h00FF}, err);
    checkVal("pslverr", {31'd0, err}, 32'd1);
    modelMul(w, 32'h0001_2345, 32'hFFFF_FF03, 32'h8000_0010);
    checkOutcome();
    apbRead(`EXEC_INSTR, rd, err);
    checkVal("INSTR", rd, w);
    reportTest(5, "busy refusal");

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
